//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = tb_vic_registers
FILELIST  = all.f

SOURCES   = $(wildcard logic/*.sv) $(wildcard testbench/*.sv)
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- all.f
logic/vic_reg_pkg.sv
logic/vic_bus_access.sv
logic/vic_control_regs.sv
logic/vic_irq_regs.sv
logic/vic_read_mux.sv
logic/vic_registers.sv
testbench/tb_clock_gen.sv
testbench/tb_vic_registers.sv

//--- logic/vic_bus_access.sv
`timescale 1ns/10ps

module vic_bus_access (
        input  logic                  clk_dot4x,
        input  logic                  rst,
        input  logic                  clk_phi,
        input  logic                  phi_phase_start_dav,
        input  logic                  phi_phase_start_dav_plus_1,
        input  logic                  ras,
        input  logic                  ce,
        input  logic                  rw,
        input  logic                  aec,
        input  vic_reg_pkg::reg_addr_t adi,
        input  vic_reg_pkg::reg_data_t dbi,
        output vic_reg_pkg::bus_req_t  req,
        output logic                  rd_stb,
        output logic                  wr_stb,
        output logic                  phase_end
);

        vic_reg_pkg::access_state_t state;
        vic_reg_pkg::reg_addr_t     addr_q;
        logic                       latch_addr;
        logic                       cpu_sel;

        // address is taken once per phase while phi is high and ras low
        assign latch_addr = (state == vic_reg_pkg::ACC_IDLE) && clk_phi && !ras;
        assign cpu_sel    = aec && !ce;

        assign rd_stb = (state == vic_reg_pkg::ACC_LATCHED) && cpu_sel && rw;

        // writes land on the data valid point only
        assign wr_stb = phi_phase_start_dav && cpu_sel && !rw &&
                        ((state == vic_reg_pkg::ACC_LATCHED) ||
                         (state == vic_reg_pkg::ACC_READ_DONE));

        assign phase_end = phi_phase_start_dav_plus_1 && !clk_phi;

        assign req.addr = addr_q;
        assign req.data = dbi;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        state <= vic_reg_pkg::ACC_IDLE;
                end else if (phi_phase_start_dav_plus_1) begin
                        state <= vic_reg_pkg::ACC_IDLE;
                end else if (latch_addr) begin
                        state <= vic_reg_pkg::ACC_LATCHED;
                end else if (rd_stb) begin
                        state <= vic_reg_pkg::ACC_READ_DONE;
                end
        end

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        addr_q <= '0;
                end else if (latch_addr) begin
                        addr_q <= adi;
                end
        end

        a_no_rd_wr_overlap: assert property (@(posedge clk_dot4x) disable iff (rst)
                !(rd_stb && wr_stb));

        // one read strobe per access
        a_rd_single: assert property (@(posedge clk_dot4x) disable iff (rst)
                rd_stb |=> !rd_stb);

endmodule

//--- logic/vic_control_regs.sv
`timescale 1ns/10ps

module vic_control_regs (
        input  logic                      clk_dot4x,
        input  logic                      rst,
        input  vic_reg_pkg::bus_req_t     req,
        input  logic                      wr_stb,
        output vic_reg_pkg::screen_ctrl_t screen_ctrl,
        output vic_reg_pkg::raster_t      raster_irq_compare,
        output vic_reg_pkg::mem_setup_t   mem_setup,
        output vic_reg_pkg::colors_t      colors
);

        vic_reg_pkg::reg_data_t wdata;

        assign wdata = req.data;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        // display on with the default vertical scroll
                        screen_ctrl        <= '{yscroll: 3'd3, den: 1'b1, default: '0};
                        raster_irq_compare <= '0;
                        mem_setup          <= '0;
                        colors             <= '0;
                end else if (wr_stb) begin
                        case (req.addr)
                                vic_reg_pkg::REG_SCREEN_CONTROL_1: begin
                                        screen_ctrl.yscroll   <= wdata[2:0];
                                        screen_ctrl.rsel      <= wdata[3];
                                        screen_ctrl.den       <= wdata[4];
                                        screen_ctrl.bmm       <= wdata[5];
                                        screen_ctrl.ecm       <= wdata[6];
                                        // compare bit 8 shares this register
                                        raster_irq_compare[8] <= wdata[7];
                                end
                                vic_reg_pkg::REG_RASTER_LINE: begin
                                        raster_irq_compare[7:0] <= wdata;
                                end
                                vic_reg_pkg::REG_SCREEN_CONTROL_2: begin
                                        screen_ctrl.xscroll <= wdata[2:0];
                                        screen_ctrl.csel    <= wdata[3];
                                        screen_ctrl.mcm     <= wdata[4];
                                        screen_ctrl.res     <= wdata[5];
                                end
                                vic_reg_pkg::REG_MEMORY_SETUP: begin
                                        // bit 0 unused
                                        mem_setup.cb <= wdata[3:1];
                                        mem_setup.vm <= wdata[7:4];
                                end
                                vic_reg_pkg::REG_BORDER_COLOR: begin
                                        colors.ec <= wdata[3:0];
                                end
                                vic_reg_pkg::REG_BACKGROUND_COLOR_0: begin
                                        colors.b0c <= wdata[3:0];
                                end
                                vic_reg_pkg::REG_BACKGROUND_COLOR_1: begin
                                        colors.b1c <= wdata[3:0];
                                end
                                vic_reg_pkg::REG_BACKGROUND_COLOR_2: begin
                                        colors.b2c <= wdata[3:0];
                                end
                                vic_reg_pkg::REG_BACKGROUND_COLOR_3: begin
                                        colors.b3c <= wdata[3:0];
                                end
                                default: begin
                                end
                        endcase
                end
        end

        a_reset_screen: assert property (@(posedge clk_dot4x)
                $fell(rst) |-> (screen_ctrl.den && screen_ctrl.yscroll == 3'd3));

endmodule

//--- logic/vic_irq_regs.sv
`timescale 1ns/10ps

module vic_irq_regs (
        input  logic                   clk_dot4x,
        input  logic                   rst,
        input  vic_reg_pkg::bus_req_t  req,
        input  logic                   wr_stb,
        input  logic                   phase_end,
        output vic_reg_pkg::irq_bits_t irq_en,
        output vic_reg_pkg::irq_bits_t irq_clr
);

        logic status_wr;
        logic control_wr;

        assign status_wr  = wr_stb && (req.addr == vic_reg_pkg::REG_INTERRUPT_STATUS);
        assign control_wr = wr_stb && (req.addr == vic_reg_pkg::REG_INTERRUPT_CONTROL);

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        irq_en <= '0;
                end else if (control_wr) begin
                        irq_en <= vic_reg_pkg::irq_bits_t'(req.data[3:0]);
                end
        end

        // writing a one acknowledges that source, pulse lasts to phase end
        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        irq_clr <= '0;
                end else if (status_wr) begin
                        irq_clr <= vic_reg_pkg::irq_bits_t'(req.data[3:0]);
                end else if (phase_end) begin
                        irq_clr <= '0;
                end
        end

        a_clr_ends: assert property (@(posedge clk_dot4x) disable iff (rst)
                (phase_end && !status_wr) |=> (irq_clr == '0));

endmodule

//--- logic/vic_read_mux.sv
`timescale 1ns/10ps

module vic_read_mux (
        input  logic                      clk_dot4x,
        input  logic                      rst,
        input  vic_reg_pkg::bus_req_t     req,
        input  logic                      rd_stb,
        input  vic_reg_pkg::screen_ctrl_t screen_ctrl,
        input  vic_reg_pkg::raster_t      raster_line,
        input  vic_reg_pkg::mem_setup_t   mem_setup,
        input  vic_reg_pkg::colors_t      colors,
        input  vic_reg_pkg::irq_bits_t    irq_en,
        input  logic                      irq,
        input  vic_reg_pkg::irq_bits_t    irq_flags,
        output vic_reg_pkg::reg_data_t    dbo
);

        vic_reg_pkg::reg_data_t rd_byte;

        always_comb begin
                case (req.addr)
                        vic_reg_pkg::REG_SCREEN_CONTROL_1:
                                rd_byte = {raster_line[8], screen_ctrl.ecm, screen_ctrl.bmm,
                                           screen_ctrl.den, screen_ctrl.rsel,
                                           screen_ctrl.yscroll};
                        // current line, not the compare value
                        vic_reg_pkg::REG_RASTER_LINE:
                                rd_byte = raster_line[7:0];
                        vic_reg_pkg::REG_SCREEN_CONTROL_2:
                                rd_byte = {2'b11, screen_ctrl.res, screen_ctrl.mcm,
                                           screen_ctrl.csel, screen_ctrl.xscroll};
                        vic_reg_pkg::REG_MEMORY_SETUP:
                                rd_byte = {mem_setup.vm, mem_setup.cb, 1'b1};
                        // irq comes in already active low
                        vic_reg_pkg::REG_INTERRUPT_STATUS:
                                rd_byte = {irq, 3'b111, irq_flags};
                        vic_reg_pkg::REG_INTERRUPT_CONTROL:
                                rd_byte = {4'hF, irq_en};
                        vic_reg_pkg::REG_BORDER_COLOR:
                                rd_byte = {4'hF, colors.ec};
                        vic_reg_pkg::REG_BACKGROUND_COLOR_0:
                                rd_byte = {4'hF, colors.b0c};
                        vic_reg_pkg::REG_BACKGROUND_COLOR_1:
                                rd_byte = {4'hF, colors.b1c};
                        vic_reg_pkg::REG_BACKGROUND_COLOR_2:
                                rd_byte = {4'hF, colors.b2c};
                        vic_reg_pkg::REG_BACKGROUND_COLOR_3:
                                rd_byte = {4'hF, colors.b3c};
                        default:
                                rd_byte = vic_reg_pkg::UNMAPPED_READ;
                endcase
        end

        // dbo holds between reads
        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        dbo <= vic_reg_pkg::UNMAPPED_READ;
                end else if (rd_stb) begin
                        dbo <= rd_byte;
                end
        end

endmodule

//--- logic/vic_reg_pkg.sv
package vic_reg_pkg;

        // widths that carry a meaning
        typedef logic [5:0] reg_addr_t;
        typedef logic [7:0] reg_data_t;
        typedef logic [3:0] color_t;
        typedef logic [8:0] raster_t;

        // register map, sprite and light pen addresses left out
        parameter reg_addr_t REG_SCREEN_CONTROL_1   = 6'h11;
        parameter reg_addr_t REG_RASTER_LINE        = 6'h12;
        parameter reg_addr_t REG_SCREEN_CONTROL_2   = 6'h16;
        parameter reg_addr_t REG_MEMORY_SETUP       = 6'h18;
        parameter reg_addr_t REG_INTERRUPT_STATUS   = 6'h19;
        parameter reg_addr_t REG_INTERRUPT_CONTROL  = 6'h1a;
        parameter reg_addr_t REG_BORDER_COLOR       = 6'h20;
        parameter reg_addr_t REG_BACKGROUND_COLOR_0 = 6'h21;
        parameter reg_addr_t REG_BACKGROUND_COLOR_1 = 6'h22;
        parameter reg_addr_t REG_BACKGROUND_COLOR_2 = 6'h23;
        parameter reg_addr_t REG_BACKGROUND_COLOR_3 = 6'h24;

        // open bus value for anything not decoded
        parameter reg_data_t UNMAPPED_READ = 8'hFF;

        // latched address plus the data byte of the current phase
        typedef struct packed {
                reg_addr_t addr;
                reg_data_t data;
        } bus_req_t;

        typedef struct packed {
                logic [2:0] yscroll;
                logic       rsel;
                logic       den;
                logic       bmm;
                logic       ecm;
                logic [2:0] xscroll;
                logic       csel;
                logic       mcm;
                logic       res;
        } screen_ctrl_t;

        typedef struct packed {
                logic [2:0] cb;
                logic [3:0] vm;
        } mem_setup_t;

        typedef struct packed {
                color_t ec;
                color_t b0c;
                color_t b1c;
                color_t b2c;
                color_t b3c;
        } colors_t;

        // bit 0 is rst, matching the data bits of 0x19 and 0x1a
        typedef struct packed {
                logic lp;
                logic mmc;
                logic mbc;
                logic rst;
        } irq_bits_t;

        typedef enum logic [1:0] {
                ACC_IDLE,
                ACC_LATCHED,
                ACC_READ_DONE
        } access_state_t;

endpackage

//--- logic/vic_registers.sv
`timescale 1ns/10ps

module vic_registers (
        input  logic                      clk_dot4x,
        input  logic                      rst,
        input  logic                      clk_phi,
        input  logic                      phi_phase_start_dav,
        input  logic                      phi_phase_start_dav_plus_1,
        input  logic                      ras,
        input  logic                      ce,
        input  logic                      rw,
        input  logic                      aec,
        input  vic_reg_pkg::reg_addr_t    adi,
        input  vic_reg_pkg::reg_data_t    dbi,
        input  vic_reg_pkg::raster_t      raster_line,
        input  logic                      irq,
        input  vic_reg_pkg::irq_bits_t    irq_flags,
        output vic_reg_pkg::screen_ctrl_t screen_ctrl,
        output vic_reg_pkg::raster_t      raster_irq_compare,
        output vic_reg_pkg::mem_setup_t   mem_setup,
        output vic_reg_pkg::colors_t      colors,
        output vic_reg_pkg::irq_bits_t    irq_en,
        output vic_reg_pkg::irq_bits_t    irq_clr,
        output vic_reg_pkg::reg_data_t    dbo
);

        vic_reg_pkg::bus_req_t req;
        logic                  rd_stb;
        logic                  wr_stb;
        logic                  phase_end;

        vic_bus_access u_bus_access (
                .clk_dot4x                  (clk_dot4x),
                .rst                        (rst),
                .clk_phi                    (clk_phi),
                .phi_phase_start_dav        (phi_phase_start_dav),
                .phi_phase_start_dav_plus_1 (phi_phase_start_dav_plus_1),
                .ras                        (ras),
                .ce                         (ce),
                .rw                         (rw),
                .aec                        (aec),
                .adi                        (adi),
                .dbi                        (dbi),
                .req                        (req),
                .rd_stb                     (rd_stb),
                .wr_stb                     (wr_stb),
                .phase_end                  (phase_end)
        );

        vic_control_regs u_control_regs (
                .clk_dot4x          (clk_dot4x),
                .rst                (rst),
                .req                (req),
                .wr_stb             (wr_stb),
                .screen_ctrl        (screen_ctrl),
                .raster_irq_compare (raster_irq_compare),
                .mem_setup          (mem_setup),
                .colors             (colors)
        );

        vic_irq_regs u_irq_regs (
                .clk_dot4x (clk_dot4x),
                .rst       (rst),
                .req       (req),
                .wr_stb    (wr_stb),
                .phase_end (phase_end),
                .irq_en    (irq_en),
                .irq_clr   (irq_clr)
        );

        vic_read_mux u_read_mux (
                .clk_dot4x   (clk_dot4x),
                .rst         (rst),
                .req         (req),
                .rd_stb      (rd_stb),
                .screen_ctrl (screen_ctrl),
                .raster_line (raster_line),
                .mem_setup   (mem_setup),
                .colors      (colors),
                .irq_en      (irq_en),
                .irq         (irq),
                .irq_flags   (irq_flags),
                .dbo         (dbo)
        );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
        output logic clk_dot4x,
        output logic rst
);

        // 4 ns period
        initial begin
                clk_dot4x = 1'b0;
                forever #2 clk_dot4x = ~clk_dot4x;
        end

        // released on a rising edge after 10 cycles
        initial begin
                rst = 1'b1;
                repeat (10) @(posedge clk_dot4x);
                rst <= 1'b0;
        end

endmodule

//--- testbench/tb_vic_registers.sv
`timescale 1ns/10ps

module tb_vic_registers;

        // about 46 bus phases of 8 cycles each, well under this limit
        localparam int TIMEOUT_CYCLES = 2000;

        logic                      clk_dot4x;
        logic                      rst;
        logic                      clk_phi;
        logic                      phi_phase_start_dav;
        logic                      phi_phase_start_dav_plus_1;
        logic                      ras;
        logic                      ce;
        logic                      rw;
        logic                      aec;
        vic_reg_pkg::reg_addr_t    adi;
        vic_reg_pkg::reg_data_t    dbi;
        vic_reg_pkg::raster_t      raster_line;
        logic                      irq;
        vic_reg_pkg::irq_bits_t    irq_flags;
        vic_reg_pkg::screen_ctrl_t screen_ctrl;
        vic_reg_pkg::raster_t      raster_irq_compare;
        vic_reg_pkg::mem_setup_t   mem_setup;
        vic_reg_pkg::colors_t      colors;
        vic_reg_pkg::irq_bits_t    irq_en;
        vic_reg_pkg::irq_bits_t    irq_clr;
        vic_reg_pkg::reg_data_t    dbo;

        // expected register contents
        vic_reg_pkg::screen_ctrl_t exp_screen;
        vic_reg_pkg::raster_t      exp_cmp;
        vic_reg_pkg::mem_setup_t   exp_mem;
        vic_reg_pkg::colors_t      exp_colors;
        vic_reg_pkg::irq_bits_t    exp_en;

        int error_count = 0;
        int check_count = 0;
        int cycle_count = 0;

        tb_clock_gen u_clock_gen (
                .clk_dot4x (clk_dot4x),
                .rst       (rst)
        );

        vic_registers dut (.*);

        always @(posedge clk_dot4x) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count == TIMEOUT_CYCLES) begin
                        $display("run timed out after %0d cycles", cycle_count);
                        $display("TESTBENCH FAILED");
                        $finish;
                end
        end

        task automatic check_data(input string name, input vic_reg_pkg::reg_data_t exp,
                                  input vic_reg_pkg::reg_data_t act);
                check_count++;
                if (act !== exp) begin
                        error_count++;
                        $display("ERR %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic check_screen(input string name, input vic_reg_pkg::screen_ctrl_t exp,
                                    input vic_reg_pkg::screen_ctrl_t act);
                check_count++;
                if (act !== exp) begin
                        error_count++;
                        $display("ERR %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic check_mem(input string name, input vic_reg_pkg::mem_setup_t exp,
                                 input vic_reg_pkg::mem_setup_t act);
                check_count++;
                if (act !== exp) begin
                        error_count++;
                        $display("ERR %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic check_colors(input string name, input vic_reg_pkg::colors_t exp,
                                    input vic_reg_pkg::colors_t act);
                check_count++;
                if (act !== exp) begin
                        error_count++;
                        $display("ERR %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic check_raster(input string name, input vic_reg_pkg::raster_t exp,
                                    input vic_reg_pkg::raster_t act);
                check_count++;
                if (act !== exp) begin
                        error_count++;
                        $display("ERR %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic check_irq(input string name, input vic_reg_pkg::irq_bits_t exp,
                                 input vic_reg_pkg::irq_bits_t act);
                check_count++;
                if (act !== exp) begin
                        error_count++;
                        $display("ERR %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic check_regs(input string name);
                check_screen({name, " screen_ctrl"}, exp_screen, screen_ctrl);
                check_raster({name, " raster_irq_compare"}, exp_cmp, raster_irq_compare);
                check_mem({name, " mem_setup"}, exp_mem, mem_setup);
                check_colors({name, " colors"}, exp_colors, colors);
                check_irq({name, " irq_en"}, exp_en, irq_en);
        endtask

        // register field layout as seen from the CPU
        function automatic void model_write(input vic_reg_pkg::reg_addr_t addr,
                                            input vic_reg_pkg::reg_data_t d);
                case (addr)
                        vic_reg_pkg::REG_SCREEN_CONTROL_1:
                                {exp_cmp[8], exp_screen.ecm, exp_screen.bmm, exp_screen.den,
                                 exp_screen.rsel, exp_screen.yscroll} = d;
                        vic_reg_pkg::REG_RASTER_LINE: exp_cmp[7:0] = d;
                        vic_reg_pkg::REG_SCREEN_CONTROL_2:
                                {exp_screen.res, exp_screen.mcm, exp_screen.csel,
                                 exp_screen.xscroll} = d[5:0];
                        vic_reg_pkg::REG_MEMORY_SETUP: {exp_mem.vm, exp_mem.cb} = d[7:1];
                        vic_reg_pkg::REG_INTERRUPT_CONTROL: exp_en = d[3:0];
                        vic_reg_pkg::REG_BORDER_COLOR: exp_colors.ec = d[3:0];
                        vic_reg_pkg::REG_BACKGROUND_COLOR_0: exp_colors.b0c = d[3:0];
                        vic_reg_pkg::REG_BACKGROUND_COLOR_1: exp_colors.b1c = d[3:0];
                        vic_reg_pkg::REG_BACKGROUND_COLOR_2: exp_colors.b2c = d[3:0];
                        vic_reg_pkg::REG_BACKGROUND_COLOR_3: exp_colors.b3c = d[3:0];
                        default: ;
                endcase
        endfunction

        function automatic vic_reg_pkg::reg_data_t expected_byte(
                        input vic_reg_pkg::reg_addr_t addr);
                case (addr)
                        vic_reg_pkg::REG_SCREEN_CONTROL_1:
                                return {raster_line[8], exp_screen.ecm, exp_screen.bmm,
                                        exp_screen.den, exp_screen.rsel, exp_screen.yscroll};
                        vic_reg_pkg::REG_RASTER_LINE: return raster_line[7:0];
                        vic_reg_pkg::REG_SCREEN_CONTROL_2:
                                return {2'b11, exp_screen.res, exp_screen.mcm,
                                        exp_screen.csel, exp_screen.xscroll};
                        vic_reg_pkg::REG_MEMORY_SETUP: return {exp_mem.vm, exp_mem.cb, 1'b1};
                        vic_reg_pkg::REG_INTERRUPT_STATUS: return {irq, 3'b111, irq_flags};
                        vic_reg_pkg::REG_INTERRUPT_CONTROL: return {4'hF, exp_en};
                        vic_reg_pkg::REG_BORDER_COLOR: return {4'hF, exp_colors.ec};
                        vic_reg_pkg::REG_BACKGROUND_COLOR_0: return {4'hF, exp_colors.b0c};
                        vic_reg_pkg::REG_BACKGROUND_COLOR_1: return {4'hF, exp_colors.b1c};
                        vic_reg_pkg::REG_BACKGROUND_COLOR_2: return {4'hF, exp_colors.b2c};
                        vic_reg_pkg::REG_BACKGROUND_COLOR_3: return {4'hF, exp_colors.b3c};
                        default: return 8'hFF;
                endcase
        endfunction

        // one full bus phase, dbo and irq_clr sampled on falling edges
        task automatic bus_access(input vic_reg_pkg::reg_addr_t addr,
                                  input vic_reg_pkg::reg_data_t data, input logic write,
                                  input logic cpu_en, output vic_reg_pkg::reg_data_t rdata,
                                  output vic_reg_pkg::irq_bits_t clr_mid);
                @(posedge clk_dot4x);
                clk_phi <= 1'b1;
                ras     <= 1'b0;
                adi     <= addr;
                dbi     <= data;
                rw      <= !write;
                @(posedge clk_dot4x);
                @(posedge clk_dot4x);
                aec <= 1'b1;
                ce  <= !cpu_en;
                @(posedge clk_dot4x);
                phi_phase_start_dav <= 1'b1;
                @(posedge clk_dot4x);
                phi_phase_start_dav <= 1'b0;
                @(negedge clk_dot4x);
                clr_mid = irq_clr;
                @(posedge clk_dot4x);
                clk_phi                    <= 1'b0;
                ras                        <= 1'b1;
                aec                        <= 1'b0;
                ce                         <= 1'b1;
                phi_phase_start_dav_plus_1 <= 1'b1;
                @(posedge clk_dot4x);
                phi_phase_start_dav_plus_1 <= 1'b0;
                rw                         <= 1'b1;
                @(posedge clk_dot4x);
                @(negedge clk_dot4x);
                rdata = dbo;
        endtask

        task automatic write_reg(input vic_reg_pkg::reg_addr_t addr,
                                 input vic_reg_pkg::reg_data_t data);
                vic_reg_pkg::reg_data_t rdata;
                vic_reg_pkg::irq_bits_t clr;
                bus_access(addr, data, 1'b1, 1'b1, rdata, clr);
                model_write(addr, data);
        endtask

        task automatic read_check(input string name, input vic_reg_pkg::reg_addr_t addr);
                vic_reg_pkg::reg_data_t rdata;
                vic_reg_pkg::irq_bits_t clr;
                bus_access(addr, 8'h00, 1'b0, 1'b1, rdata, clr);
                check_data(name, expected_byte(addr), rdata);
        endtask

        task automatic drive_status(input vic_reg_pkg::raster_t line, input logic irq_n,
                                    input vic_reg_pkg::irq_bits_t flags);
                @(posedge clk_dot4x);
                raster_line <= line;
                irq         <= irq_n;
                irq_flags   <= flags;
        endtask

        task automatic reset_values();
                vic_reg_pkg::reg_data_t rdata;
                vic_reg_pkg::irq_bits_t clr;
                @(negedge clk_dot4x);
                check_data("reset dbo", 8'hFF, dbo);
                bus_access(vic_reg_pkg::REG_SCREEN_CONTROL_1, 8'h00, 1'b0, 1'b1, rdata, clr);
                check_data("reset 0x11", 8'h13, rdata);
                bus_access(vic_reg_pkg::REG_SCREEN_CONTROL_2, 8'h00, 1'b0, 1'b1, rdata, clr);
                check_data("reset 0x16", 8'hC0, rdata);
                bus_access(vic_reg_pkg::REG_INTERRUPT_CONTROL, 8'h00, 1'b0, 1'b1, rdata, clr);
                check_data("reset 0x1a", 8'hF0, rdata);
                check_irq("reset irq_clr", '0, irq_clr);
        endtask

        task automatic write_readback();
                vic_reg_pkg::reg_addr_t addrs[8];
                addrs = '{vic_reg_pkg::REG_SCREEN_CONTROL_1, vic_reg_pkg::REG_SCREEN_CONTROL_2,
                          vic_reg_pkg::REG_MEMORY_SETUP, vic_reg_pkg::REG_BORDER_COLOR,
                          vic_reg_pkg::REG_BACKGROUND_COLOR_0, vic_reg_pkg::REG_BACKGROUND_COLOR_1,
                          vic_reg_pkg::REG_BACKGROUND_COLOR_2, vic_reg_pkg::REG_BACKGROUND_COLOR_3};
                foreach (addrs[i]) begin
                        write_reg(addrs[i], 8'($urandom));
                        check_regs($sformatf("write 0x%h", addrs[i]));
                end
                drive_status(9'($urandom), 1'b1, '0);
                foreach (addrs[i]) begin
                        read_check($sformatf("readback 0x%h", addrs[i]), addrs[i]);
                end
        endtask

        task automatic raster_compare();
                vic_reg_pkg::reg_data_t lo;
                vic_reg_pkg::reg_data_t hi;
                lo = 8'($urandom);
                hi = 8'($urandom);
                write_reg(vic_reg_pkg::REG_RASTER_LINE, lo);
                write_reg(vic_reg_pkg::REG_SCREEN_CONTROL_1, hi);
                check_raster("raster compare", {hi[7], lo}, raster_irq_compare);
                check_regs("raster compare");
                // current line differs from the compare value in every bit
                drive_status(~{hi[7], lo}, 1'b1, '0);
                read_check("raster 0x11", vic_reg_pkg::REG_SCREEN_CONTROL_1);
                read_check("raster 0x12", vic_reg_pkg::REG_RASTER_LINE);
        endtask

        task automatic interrupts();
                vic_reg_pkg::reg_data_t data;
                vic_reg_pkg::reg_data_t rdata;
                vic_reg_pkg::irq_bits_t clr;
                repeat (3) begin
                        data = 8'($urandom);
                        write_reg(vic_reg_pkg::REG_INTERRUPT_CONTROL, data);
                        check_irq("irq enable", data[3:0], irq_en);
                        read_check("irq enable readback", vic_reg_pkg::REG_INTERRUPT_CONTROL);
                        drive_status(raster_line, ($urandom & 1) != 0, 4'($urandom));
                        read_check("irq status", vic_reg_pkg::REG_INTERRUPT_STATUS);
                        // at least one source acknowledged
                        data = 8'($urandom) | 8'h01;
                        bus_access(vic_reg_pkg::REG_INTERRUPT_STATUS, data, 1'b1, 1'b1, rdata,
                                   clr);
                        check_irq("irq clear pulse", data[3:0], clr);
                        check_irq("irq clear end", '0, irq_clr);
                end
        endtask

        task automatic unmapped_access();
                vic_reg_pkg::reg_addr_t addrs[5];
                vic_reg_pkg::reg_data_t rdata;
                vic_reg_pkg::irq_bits_t clr;
                // sprite x, light pen x, sprite enable, collision, top of map
                addrs = '{6'h00, 6'h13, 6'h15, 6'h1e, 6'h3f};
                foreach (addrs[i]) begin
                        bus_access(addrs[i], 8'h00, 1'b0, 1'b1, rdata, clr);
                        check_data($sformatf("unmapped read 0x%h", addrs[i]), 8'hFF, rdata);
                end
                foreach (addrs[i]) begin
                        bus_access(addrs[i], 8'($urandom), 1'b1, 1'b1, rdata, clr);
                        check_regs($sformatf("unmapped write 0x%h", addrs[i]));
                end
                bus_access(vic_reg_pkg::REG_BORDER_COLOR, {4'h0, ~exp_colors.ec}, 1'b1, 1'b0,
                           rdata, clr);
                check_regs("write with ce high");
        endtask

        initial begin
                void'($urandom(5421));
                clk_phi                    <= 1'b0;
                phi_phase_start_dav        <= 1'b0;
                phi_phase_start_dav_plus_1 <= 1'b0;
                ras                        <= 1'b1;
                ce                         <= 1'b1;
                rw                         <= 1'b1;
                aec                        <= 1'b0;
                adi                        <= '0;
                dbi                        <= '0;
                raster_line                <= '0;
                irq                        <= 1'b1;
                irq_flags                  <= '0;
                exp_screen = '{yscroll: 3'd3, den: 1'b1, default: '0};
                exp_cmp    = '0;
                exp_mem    = '0;
                exp_colors = '0;
                exp_en     = '0;
                @(posedge clk_dot4x);
                while (rst) @(posedge clk_dot4x);
                reset_values();
                write_readback();
                raster_compare();
                interrupts();
                unmapped_access();
                $display("checks: %0d, errors: %0d", check_count, error_count);
                if (error_count == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule
